/* sim.f */
+incdir+.
graph_cu_pkg.sv
sync_fifo.sv
rr_arbiter.sv
vertex_unit.sv
response_router.sv
graph_algorithm_control.sv
tb_graph_algorithm_control.sv

/* Bender.yml */
package:
  name: graph_algorithm_control

sources:
  - include_dirs:
      - .
    files:
      - graph_cu_pkg.sv
      - sync_fifo.sv
      - rr_arbiter.sv
      - vertex_unit.sv
      - response_router.sv
      - graph_algorithm_control.sv
  - target: simulation
    files:
      - tb_graph_algorithm_control.sv

/* tb_graph_algorithm_control.sv */
////////////////////////////////////////////////////////////
// Testbench for the graph compute cluster control core
// Random jobs and bus grants from a fixed seed, a memory-side
// model that answers every read, and counting models
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_graph_algorithm_control
	import graph_cu_pkg::*;
();

	localparam int CLOCK_PERIOD    = 20;
	localparam int RESET_CYCLES    = 16;
	localparam int UNITS_USED      = 3;
	localparam int JOBS_FREE       = 24;
	localparam int JOBS_STALL      = 16;
	localparam int STALL_CYCLES    = 150;
	localparam int IDLE_LIMIT      = 3000;
	localparam int NUM_TESTS       = 5;
	localparam int WATCHDOG_CYCLES = 200 * (JOBS_FREE + JOBS_STALL) + 2000;

	logic        clock;
	logic        rstn;
	logic        enabled_in             = 1'b0;
	cu_count_t   cu_configure           = '0;
	logic        vertex_job_valid       = 1'b0;
	vertex_id_t  vertex_job_id          = '0;
	edge_count_t vertex_job_edges       = '0;
	logic        vertex_job_request;
	logic        read_command_bus_grant = 1'b0;
	logic        read_command_bus_request;
	logic        read_command_valid;
	cu_id_t      read_command_cu;
	vertex_id_t  read_command_vertex;
	logic        read_response_valid    = 1'b0;
	cu_id_t      read_response_cu       = '0;
	edge_count_t vertex_done_count;
	edge_count_t edge_done_count;

	// Stimulus and model state
	int unsigned lcg_state        = 47;
	int          errs [1:NUM_TESTS];
	int          cur_test         = 1;
	int          jobs_to_send     = 0;
	int          gap_left         = 0;
	int          jobs_sent        = 0;
	int          edges_sent       = 0;
	int          commands_seen    = 0;
	int          cycle            = 0;
	int          last_vertex_done = 0;
	int          last_edge_done   = 0;
	int          cmds_left [int];
	int          resp_cu_q [$];
	int          resp_due_q [$];
	logic        hold_grants      = 1'b0;
	logic        watch_request    = 1'b0;
	logic        request_fell     = 1'b0;
	logic        request_seen     = 1'b0;
	logic        bus_request_seen = 1'b0;
	logic [1:0]  grant_hist       = 2'b00;

	graph_algorithm_control u_graph_algorithm_control (
		.clock                   (clock),
		.rstn                    (rstn),
		.enabled_in              (enabled_in),
		.cu_configure            (cu_configure),
		.vertex_job_valid        (vertex_job_valid),
		.vertex_job_id           (vertex_job_id),
		.vertex_job_edges        (vertex_job_edges),
		.vertex_job_request      (vertex_job_request),
		.read_command_bus_grant  (read_command_bus_grant),
		.read_command_bus_request(read_command_bus_request),
		.read_command_valid      (read_command_valid),
		.read_command_cu         (read_command_cu),
		.read_command_vertex     (read_command_vertex),
		.read_response_valid     (read_response_valid),
		.read_response_cu        (read_response_cu),
		.vertex_done_count       (vertex_done_count),
		.edge_done_count         (edge_done_count)
	);

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// LCG step returning a value from its upper bits
	function automatic int unsigned random_below(input int unsigned range);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return (lcg_state >> 16) % range;
	endfunction

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("error at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
		errs[cur_test]++;
	endtask

	task automatic report_bound(input string name, input string relation, input int bound,
			input int actual);
		$display("error at %0d ns: %s expected %s %0d, got %0d", $time, name, relation, bound,
			actual);
		errs[cur_test]++;
	endtask

	task automatic report_problem(input string text);
		$display("error at %0d ns: %s", $time, text);
		errs[cur_test]++;
	endtask

	task automatic finish_test(input int num, input string name);
		$display("test %0d %s: %s, %0d errors", num, name, (errs[num] == 0) ? "ok" : "FAIL",
			errs[num]);
	endtask

	// Every job including zero-edge ones must have seen exactly its edge count
	task automatic check_vertex_commands();
		foreach (cmds_left[v]) begin
			assert (cmds_left[v] == 0) else
				report_problem($sformatf("vertex 0x%h is missing %0d read commands", v,
					cmds_left[v]));
		end
	endtask

	// Idle means all jobs sent and every expected read seen and answered
	task automatic wait_idle();
		int waited;

		waited = 0;
		while (!(jobs_to_send == 0 && commands_seen == edges_sent &&
				resp_cu_q.size() == 0) && waited < IDLE_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		assert (waited < IDLE_LIMIT) else
			report_problem($sformatf("DUT did not go idle within %0d cycles", IDLE_LIMIT));
	endtask

	////////////////////////////////////////////////////////////
	// Clock and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Job source, bus grants and memory responses
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		int unsigned edges;
		vertex_id_t  vid;

		cycle = cycle + 1;
		if (rstn) begin
			vertex_job_valid <= 1'b0;
			// Source only sends while the DUT asks for jobs
			if (jobs_to_send > 0 && request_seen) begin
				if (gap_left > 0) begin
					gap_left = gap_left - 1;
				end else begin
					edges = random_below(8);
					vid   = vertex_id_t'(16'h0100 + jobs_sent);
					vertex_job_valid <= 1'b1;
					vertex_job_id    <= vid;
					vertex_job_edges <= edge_count_t'(edges);
					cmds_left[int'(vid)] = int'(edges);
					jobs_sent    = jobs_sent + 1;
					edges_sent   = edges_sent + int'(edges);
					jobs_to_send = jobs_to_send - 1;
					gap_left     = int'(random_below(4));
				end
			end

			if (!hold_grants && bus_request_seen && random_below(2) == 0)
				read_command_bus_grant <= 1'b1;
			else
				read_command_bus_grant <= 1'b0;

			if (resp_cu_q.size() > 0 && resp_due_q[0] <= cycle) begin
				read_response_valid <= 1'b1;
				read_response_cu    <= cu_id_t'(resp_cu_q.pop_front());
				void'(resp_due_q.pop_front());
			end else begin
				read_response_valid <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Output monitor sampled mid-cycle
	////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		int vid;

		if (rstn) begin
			request_seen     = vertex_job_request;
			bus_request_seen = read_command_bus_request;
			if (watch_request && !vertex_job_request)
				request_fell = 1'b1;

			if (read_command_valid) begin
				commands_seen = commands_seen + 1;
				vid = int'(read_command_vertex);
				assert (grant_hist[1]) else
					report_problem("read_command_valid without a bus grant two cycles before");
				assert (int'(read_command_cu) < UNITS_USED) else
					report_bound("read_command_cu", "below", UNITS_USED, int'(read_command_cu));
				assert (cmds_left.exists(vid)) else
					report_problem($sformatf("read command for vertex 0x%h, never sent", vid));
				if (cmds_left.exists(vid)) begin
					assert (cmds_left[vid] > 0) else
						report_problem($sformatf("vertex 0x%h got more reads than edges", vid));
					if (cmds_left[vid] > 0)
						cmds_left[vid]--;
				end
				// Memory side answers after a random delay
				resp_cu_q.push_back(int'(read_command_cu));
				resp_due_q.push_back(cycle + 1 + int'(random_below(12)));
			end
			grant_hist = {grant_hist[0], read_command_bus_grant};

			assert (int'(vertex_done_count) >= last_vertex_done) else
				report_bound("vertex_done_count", "at least", last_vertex_done,
					int'(vertex_done_count));
			assert (int'(vertex_done_count) <= jobs_sent) else
				report_bound("vertex_done_count", "at most", jobs_sent, int'(vertex_done_count));
			assert (int'(edge_done_count) >= last_edge_done) else
				report_bound("edge_done_count", "at least", last_edge_done,
					int'(edge_done_count));
			assert (int'(edge_done_count) <= edges_sent) else
				report_bound("edge_done_count", "at most", edges_sent, int'(edge_done_count));
			last_vertex_done = int'(vertex_done_count);
			last_edge_done   = int'(edge_done_count);
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int failing;

		rstn = 1'b0;
		for (int t = 1; t <= NUM_TESTS; t++)
			errs[t] = 0;
		repeat (RESET_CYCLES) @(posedge clock);
		rstn <= 1'b1;
		@(negedge clock);

		cur_test = 1;
		assert (!vertex_job_request) else report_mismatch("vertex_job_request", 0, 1);
		assert (!read_command_bus_request) else report_mismatch("read_command_bus_request", 0, 1);
		assert (!read_command_valid) else report_mismatch("read_command_valid", 0, 1);
		assert (vertex_done_count == '0) else
			report_mismatch("vertex_done_count", 0, int'(vertex_done_count));
		assert (edge_done_count == '0) else
			report_mismatch("edge_done_count", 0, int'(edge_done_count));
		finish_test(1, "reset values");

		// Three of four units enabled with random grants
		cur_test = 2;
		@(posedge clock);
		enabled_in   <= 1'b1;
		cu_configure <= cu_count_t'(UNITS_USED);
		@(negedge clock);
		jobs_to_send = JOBS_FREE;
		wait_idle();
		finish_test(2, "random traffic on three units");

		cur_test = 3;
		check_vertex_commands();
		finish_test(3, "commands per vertex");

		// Grants withheld so the job buffer has to push back
		cur_test = 4;
		hold_grants   = 1'b1;
		watch_request = 1'b1;
		jobs_to_send  = JOBS_STALL;
		repeat (STALL_CYCLES) @(posedge clock);
		assert (request_fell) else
			report_problem("vertex_job_request stayed high while grants were held");
		@(negedge clock);
		assert (read_command_bus_request) else
			report_mismatch("read_command_bus_request", 1, 0);
		hold_grants   = 1'b0;
		watch_request = 1'b0;
		wait_idle();
		assert (!read_command_bus_request) else
			report_mismatch("read_command_bus_request", 0, 1);
		check_vertex_commands();
		finish_test(4, "grant stall and recovery");

		cur_test = 5;
		repeat (20) @(negedge clock);
		assert (int'(vertex_done_count) == jobs_sent) else
			report_mismatch("vertex_done_count", jobs_sent, int'(vertex_done_count));
		assert (int'(edge_done_count) == edges_sent) else
			report_mismatch("edge_done_count", edges_sent, int'(edge_done_count));
		finish_test(5, "done counts");

		failing = 0;
		for (int t = 1; t <= NUM_TESTS; t++) begin
			if (errs[t] != 0)
				failing++;
		end
		$display("%0d tests run, %0d passing, %0d failing", NUM_TESTS, NUM_TESTS - failing,
			failing);
		if (failing == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* graph_algorithm_control.sv */
////////////////////////////////////////////////////////////
// Top of the graph compute cluster control core
// Buffers vertex jobs, dispatches them to the vertex units,
// merges their reads into a burst buffer for the bus and
// routes read responses back
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "graph_cu_macros.svh"

module graph_algorithm_control
	import graph_cu_pkg::*;
(
	input  logic        clock,
	input  logic        rstn,
	input  logic        enabled_in,
	input  cu_count_t   cu_configure,
	input  logic        vertex_job_valid,
	input  vertex_id_t  vertex_job_id,
	input  edge_count_t vertex_job_edges,
	output logic        vertex_job_request,
	input  logic        read_command_bus_grant,
	output logic        read_command_bus_request,
	output logic        read_command_valid,
	output cu_id_t      read_command_cu,
	output vertex_id_t  read_command_vertex,
	input  logic        read_response_valid,
	input  cu_id_t      read_response_cu,
	output edge_count_t vertex_done_count,
	output edge_count_t edge_done_count
);

	localparam int NUM_UNITS = `GRAPH_CU_NUM_UNITS;
	localparam int JOB_WIDTH = `GRAPH_CU_VERTEX_BITS + `GRAPH_CU_EDGE_BITS;
	localparam int CMD_WIDTH = `GRAPH_CU_CU_BITS + `GRAPH_CU_VERTEX_BITS;

	logic                 enabled;
	cu_count_t            cu_configure_q;
	cu_mask_t             enable_mask;
	cu_mask_t             enable_mask_next;
	logic                 job_valid_q;
	vertex_id_t           job_id_q;
	edge_count_t          job_edges_q;
	logic                 response_valid_q;
	cu_id_t               response_cu_q;
	logic                 bus_grant_q;
	logic [JOB_WIDTH-1:0] job_head;
	logic                 job_alfull;
	logic                 job_empty;
	cu_mask_t             job_requests;
	cu_mask_t             job_grant;
	vertex_id_t           dispatch_vertex;
	edge_count_t          dispatch_edges;
	cu_mask_t             unit_job_request;
	cu_mask_t             unit_cmd_request;
	cu_mask_t             cmd_requests;
	cu_mask_t             cmd_grant;
	cu_mask_t             unit_response;
	vertex_id_t           unit_cmd_vertex   [NUM_UNITS];
	edge_count_t          unit_vertex_count [NUM_UNITS];
	edge_count_t          unit_edge_count   [NUM_UNITS];
	cu_id_t               win_cu;
	vertex_id_t           win_vertex;
	logic                 merge_valid;
	cu_id_t               merge_cu;
	vertex_id_t           merge_vertex;
	logic [CMD_WIDTH-1:0] burst_head;
	logic                 burst_alfull;
	logic                 burst_empty;
	edge_count_t          vertex_sum;
	edge_count_t          edge_sum;

	////////////////////////////////////////////////////////////
	// Input registers and unit enable mask
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled          <= 1'b0;
			cu_configure_q   <= '0;
			enable_mask      <= '0;
			job_valid_q      <= 1'b0;
			response_valid_q <= 1'b0;
			bus_grant_q      <= 1'b0;
		end else begin
			enabled          <= enabled_in;
			job_valid_q      <= enabled && vertex_job_valid;
			response_valid_q <= enabled && read_response_valid;
			bus_grant_q      <= enabled && read_command_bus_grant;
			if (enabled) begin
				// A zero word keeps the previous configuration
				if (|cu_configure)
					cu_configure_q <= cu_configure;
				enable_mask <= enable_mask_next;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (enabled) begin
			job_id_q      <= vertex_job_id;
			job_edges_q   <= vertex_job_edges;
			response_cu_q <= read_response_cu;
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_UNITS; i++) begin
			enable_mask_next[i] = (cu_count_t'(i) < cu_configure_q);
		end
	end

	////////////////////////////////////////////////////////////
	// Job buffer and dispatch
	////////////////////////////////////////////////////////////

	assign vertex_job_request = enabled && !job_alfull;

	sync_fifo #(
		.WIDTH        (JOB_WIDTH),
		.DEPTH        (`GRAPH_CU_JOB_DEPTH),
		.ALFULL_MARGIN(`GRAPH_CU_ALFULL_MARGIN)
	) u_job_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_valid_q),
		.data_in ({job_id_q, job_edges_q}),
		.pop     (|job_grant),
		.data_out(job_head),
		.full    (),
		.alfull  (job_alfull),
		.empty   (job_empty)
	);

	assign job_requests = unit_job_request & {NUM_UNITS{!job_empty}};

	rr_arbiter #(
		.NUM_REQUESTS(NUM_UNITS)
	) u_job_arbiter (
		.clock   (clock),
		.rstn    (rstn),
		.requests(job_requests),
		.grant   (job_grant)
	);

	// Popped job reaches the units on the next cycle
	always_ff @(posedge clock) begin
		if (|job_grant)
			{dispatch_vertex, dispatch_edges} <= job_head;
	end

	////////////////////////////////////////////////////////////
	// Vertex units
	////////////////////////////////////////////////////////////

	for (genvar u = 0; u < NUM_UNITS; u++) begin : gen_units
		vertex_unit #(
			.UNIT_ID(u)
		) u_vertex_unit (
			.clock       (clock),
			.rstn        (rstn),
			.enabled     (enable_mask[u]),
			.job_grant   (job_grant[u]),
			.job_vertex  (dispatch_vertex),
			.job_edges   (dispatch_edges),
			.job_request (unit_job_request[u]),
			.cmd_request (unit_cmd_request[u]),
			.cmd_grant   (cmd_grant[u]),
			.cmd_vertex  (unit_cmd_vertex[u]),
			.response    (unit_response),
			.vertex_count(unit_vertex_count[u]),
			.edge_count  (unit_edge_count[u])
		);
	end

	response_router u_response_router (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.enable_mask   (enable_mask),
		.response_valid(response_valid_q),
		.response_cu   (response_cu_q),
		.unit_response (unit_response)
	);

	////////////////////////////////////////////////////////////
	// Command merge and burst buffer
	////////////////////////////////////////////////////////////

	// Units hold in issue while the burst buffer is nearly full
	assign cmd_requests = unit_cmd_request & {NUM_UNITS{!burst_alfull}};

	rr_arbiter #(
		.NUM_REQUESTS(NUM_UNITS)
	) u_cmd_arbiter (
		.clock   (clock),
		.rstn    (rstn),
		.requests(cmd_requests),
		.grant   (cmd_grant)
	);

	always_comb begin
		win_cu     = '0;
		win_vertex = '0;
		for (int k = 0; k < NUM_UNITS; k++) begin
			if (cmd_grant[k]) begin
				win_cu     = cu_id_t'(k);
				win_vertex = unit_cmd_vertex[k];
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			merge_valid <= 1'b0;
		end else begin
			merge_valid <= |cmd_grant;
		end
	end

	always_ff @(posedge clock) begin
		merge_cu     <= win_cu;
		merge_vertex <= win_vertex;
	end

	sync_fifo #(
		.WIDTH        (CMD_WIDTH),
		.DEPTH        (`GRAPH_CU_CMD_DEPTH),
		.ALFULL_MARGIN(`GRAPH_CU_ALFULL_MARGIN)
	) u_burst_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (merge_valid),
		.data_in ({merge_cu, merge_vertex}),
		.pop     (bus_grant_q),
		.data_out(burst_head),
		.full    (),
		.alfull  (burst_alfull),
		.empty   (burst_empty)
	);

	// Bus side, one command per latched grant
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_bus_request <= 1'b0;
			read_command_valid       <= 1'b0;
		end else begin
			read_command_bus_request <= !burst_empty;
			read_command_valid       <= bus_grant_q && !burst_empty;
		end
	end

	always_ff @(posedge clock) begin
		if (bus_grant_q && !burst_empty)
			{read_command_cu, read_command_vertex} <= burst_head;
	end

	////////////////////////////////////////////////////////////
	// Done counts
	////////////////////////////////////////////////////////////

	always_comb begin
		vertex_sum = '0;
		edge_sum   = '0;
		for (int n = 0; n < NUM_UNITS; n++) begin
			vertex_sum = vertex_sum + unit_vertex_count[n];
			edge_sum   = edge_sum + unit_edge_count[n];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_count <= '0;
			edge_done_count   <= '0;
		end else begin
			vertex_done_count <= vertex_sum;
			edge_done_count   <= edge_sum;
		end
	end

endmodule

/* response_router.sv */
////////////////////////////////////////////////////////////
// Steers each read response to the unit it names
// Output is a registered one-hot strobe per enabled unit
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "graph_cu_macros.svh"

module response_router
	import graph_cu_pkg::*;
(
	input  logic     clock,
	input  logic     rstn,
	input  logic     enabled,
	input  cu_mask_t enable_mask,
	input  logic     response_valid,
	input  cu_id_t   response_cu,
	output cu_mask_t unit_response
);

	cu_mask_t route_next;

	// Decode, responses for a disabled unit fall away here
	always_comb begin
		route_next = '0;
		if (enabled && response_valid) begin
			for (int u = 0; u < `GRAPH_CU_NUM_UNITS; u++) begin
				route_next[u] = (response_cu == cu_id_t'(u)) && enable_mask[u];
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			unit_response <= '0;
		end else begin
			unit_response <= route_next;
		end
	end

endmodule

/* vertex_unit.sv */
////////////////////////////////////////////////////////////
// Vertex unit, takes one job, issues one read per edge and
// counts the responses before asking for the next job
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "graph_cu_macros.svh"

module vertex_unit
	import graph_cu_pkg::*;
#(
	parameter int UNIT_ID = 0
) (
	input  logic        clock,
	input  logic        rstn,
	input  logic        enabled,
	input  logic        job_grant,
	input  vertex_id_t  job_vertex,
	input  edge_count_t job_edges,
	output logic        job_request,
	output logic        cmd_request,
	input  logic        cmd_grant,
	output vertex_id_t  cmd_vertex,
	input  cu_mask_t    response,
	output edge_count_t vertex_count,
	output edge_count_t edge_count
);

	unit_state_t state;
	vertex_id_t  vertex_q;
	edge_count_t edges_q;
	edge_count_t issue_left;
	edge_count_t response_count;
	logic        my_response;

	// Router strobes are one-hot, pick out this unit
	assign my_response = response[UNIT_ID];

	assign job_request = enabled && (state == UNIT_IDLE);
	assign cmd_request = (state == UNIT_ISSUE);
	assign cmd_vertex  = vertex_q;

	////////////////////////////////////////////////////////////
	// FSM and counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state          <= UNIT_IDLE;
			issue_left     <= '0;
			response_count <= '0;
			vertex_count   <= '0;
			edge_count     <= '0;
		end else begin
			if (my_response) begin
				edge_count     <= edge_count + `GRAPH_CU_EDGE_BITS'(1);
				response_count <= response_count + `GRAPH_CU_EDGE_BITS'(1);
			end

			case (state)
				UNIT_IDLE: begin
					if (job_grant)
						state <= UNIT_LOAD;
				end
				UNIT_LOAD: begin
					// Job data arrives one cycle behind the grant
					issue_left     <= job_edges;
					response_count <= '0;
					if (job_edges == '0) begin
						vertex_count <= vertex_count + `GRAPH_CU_EDGE_BITS'(1);
						state        <= UNIT_IDLE;
					end else begin
						state <= UNIT_ISSUE;
					end
				end
				UNIT_ISSUE: begin
					if (cmd_grant) begin
						issue_left <= issue_left - `GRAPH_CU_EDGE_BITS'(1);
						if (issue_left == `GRAPH_CU_EDGE_BITS'(1))
							state <= UNIT_DRAIN;
					end
				end
				UNIT_DRAIN: begin
					// All reads out, wait for the last response
					if (response_count == edges_q) begin
						vertex_count <= vertex_count + `GRAPH_CU_EDGE_BITS'(1);
						state        <= UNIT_IDLE;
					end
				end
				default: state <= UNIT_IDLE;
			endcase
		end
	end

	// Job payload
	always_ff @(posedge clock) begin
		if (state == UNIT_LOAD) begin
			vertex_q <= job_vertex;
			edges_q  <= job_edges;
		end
	end

endmodule

/* rr_arbiter.sv */
////////////////////////////////////////////////////////////
// Round-robin arbiter, one-hot grant to one requester a cycle
// Used for job dispatch and for merging unit read commands
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "graph_cu_macros.svh"

module rr_arbiter #(
	parameter int NUM_REQUESTS = `GRAPH_CU_NUM_UNITS
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic [NUM_REQUESTS-1:0] requests,
	output logic [NUM_REQUESTS-1:0] grant
);

	localparam int IDX_BITS = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1;

	logic [IDX_BITS-1:0] last_winner;
	logic [IDX_BITS-1:0] next_winner;

	// Search starts one past the previous winner
	always_comb begin
		int   idx;
		logic found;

		grant       = '0;
		next_winner = last_winner;
		found       = 1'b0;
		for (int k = 1; k <= NUM_REQUESTS; k++) begin
			idx = int'(last_winner) + k;
			if (idx >= NUM_REQUESTS)
				idx = idx - NUM_REQUESTS;
			if (requests[idx] && !found) begin
				grant[idx]  = 1'b1;
				next_winner = IDX_BITS'(idx);
				found       = 1'b1;
			end
		end
	end

	// Pointer holds until someone wins
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			// Requester 0 goes first after reset
			last_winner <= IDX_BITS'(NUM_REQUESTS - 1);
		end else if (|grant) begin
			last_winner <= next_winner;
		end
	end

endmodule

/* sync_fifo.sv */
////////////////////////////////////////////////////////////
// Synchronous FIFO with full, almost-full and empty flags
// Serves as the vertex job buffer and the burst command buffer
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module sync_fifo #(
	parameter int WIDTH         = 8,
	parameter int DEPTH         = 8,
	parameter int ALFULL_MARGIN = 2
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	// Wrap at DEPTH so non power of two depths also work
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Push when full and pop when empty are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full     = (count == CNT_BITS'(DEPTH));
	assign alfull   = (count >= CNT_BITS'(DEPTH - ALFULL_MARGIN));
	assign empty    = (count == '0);
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

endmodule

/* graph_cu_pkg.sv */
////////////////////////////////////////////////////////////
// Types shared by the graph compute cluster control core
// Pulled into modules by a wildcard import in the header
////////////////////////////////////////////////////////////

`include "graph_cu_macros.svh"

package graph_cu_pkg;

	// Vertex identifier carried by jobs and read commands
	typedef logic [`GRAPH_CU_VERTEX_BITS-1:0] vertex_id_t;

	// Per-job edge count, also used for the done counters
	typedef logic [`GRAPH_CU_EDGE_BITS-1:0] edge_count_t;

	// Index of one vertex unit
	typedef logic [`GRAPH_CU_CU_BITS-1:0] cu_id_t;

	// One bit per vertex unit
	typedef logic [`GRAPH_CU_NUM_UNITS-1:0] cu_mask_t;

	// Configured unit count, one bit wider so the full count fits
	typedef logic [`GRAPH_CU_CU_BITS:0] cu_count_t;

	// Vertex unit FSM
	typedef enum logic [1:0] {
		UNIT_IDLE  = 2'd0,
		UNIT_LOAD  = 2'd1,
		UNIT_ISSUE = 2'd2,
		UNIT_DRAIN = 2'd3
	} unit_state_t;

endpackage

/* graph_cu_macros.svh */
////////////////////////////////////////////////////////////
// Sizes shared by the graph compute cluster control core
// Include wherever a unit count, buffer depth or field width
// is needed
////////////////////////////////////////////////////////////

`ifndef GRAPH_CU_MACROS_SVH
`define GRAPH_CU_MACROS_SVH

// Number of vertex units in the cluster
`define GRAPH_CU_NUM_UNITS 4

// Buffer depths
`define GRAPH_CU_JOB_DEPTH 8
`define GRAPH_CU_CMD_DEPTH 8

// Free entries left when almost-full rises
`define GRAPH_CU_ALFULL_MARGIN 2

// Field widths
`define GRAPH_CU_VERTEX_BITS 16
`define GRAPH_CU_EDGE_BITS 16
`define GRAPH_CU_CU_BITS 2

`endif
